// File: softermax_row_exp.f
design/fixed_point_pkg.sv
design/softermax_pkg.sv
design/skid_buffer.sv
design/fixed_signed_cast.sv
design/softermax_lpw_pow2.sv
design/row_sum_accumulator.sv
design/softermax_row_exp.sv
test/tb_softermax_row_exp.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_softermax_row_exp
FILELIST   ?= softermax_row_exp.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?=
SIM_FLAGS  ?= --binary --timing --assert
FAIL_MSG   := Finished with errors
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_softermax_row_exp.sv
`timescale 1ns/1ns

module tb_softermax_row_exp;

  localparam int N_ITEMS = 103;
  localparam int LATENCY = 4;
  localparam int TIMEOUT = 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  score_data;
  logic        score_last;
  logic        score_valid;
  logic        score_ready;
  logic [7:0]  exp_data;
  logic        exp_last;
  logic        exp_valid;
  logic        exp_ready;
  logic [15:0] sum_data;
  logic        sum_valid;

  // Table of scores, last flags, expected exponentials and row sums at each last
  logic [7:0]  score_tab [N_ITEMS];
  logic        last_tab [N_ITEMS];
  logic [7:0]  exp_tab [N_ITEMS];
  logic [15:0] row_sum_tab [N_ITEMS];

  // Expected outputs in order as {exponential, last}
  logic [8:0]  exp_q [$];
  int          in_cycle_q [$];
  logic [15:0] sum_q [$];

  int          cycle = 0;
  int          in_idx = 0;
  int          expect_sum_at = -1;
  logic        random_ready = 1'b0;
  logic [31:0] lfsr;
  logic        stall_seen = 1'b0;
  logic [7:0]  stall_data;
  logic        stall_last;
  int          value_errors = 0;
  int          timing_errors = 0;
  int          protocol_errors = 0;

  softermax_row_exp u_softermax_row_exp (
    .clk        (clk),
    .rst_n      (rst_n),
    .score_data (score_data),
    .score_last (score_last),
    .score_valid(score_valid),
    .score_ready(score_ready),
    .exp_data   (exp_data),
    .exp_last   (exp_last),
    .exp_valid  (exp_valid),
    .exp_ready  (exp_ready),
    .sum_data   (sum_data),
    .sum_valid  (sum_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Four chord segments over the fraction followed by a right shift by the integer magnitude
  function automatic logic [7:0] pow2_model(logic [7:0] score);
    int  int_part;
    int  frac;
    int  seg;
    real x_lo;
    real x_hi;
    real chord;
    int  slope;
    int  intercept;
    int  lpw;
    int_part  = score[7] ? int'(score[7:4]) - 16 : int'(score[7:4]);
    frac      = int'(score[3:0]);
    seg       = frac / 4;
    x_lo      = seg / 4.0;
    x_hi      = (seg + 1) / 4.0;
    chord     = (2.0 ** x_hi - 2.0 ** x_lo) / (x_hi - x_lo);
    slope     = $rtoi($floor(chord * 256.0));
    intercept = $rtoi($floor((2.0 ** x_lo - chord * x_lo) * 4096.0));
    // 12 fraction bits down to 4
    lpw = ((frac * slope + intercept) >> (-int_part)) >> 8;
    if (lpw > 255) begin
      lpw = 255;
    end
    return 8'(lpw);
  endfunction

  task automatic build_table();
    int idx;
    int run;
    idx = 0;
    // Every integer part 0 to -8 with all four segments in rows of 1, 8, 12 and 15
    for (int i = 0; i < 36; i++) begin
      score_tab[idx] = 8'(-(i / 4) * 16 + (i % 4) * 4 + (i % 3));
      last_tab[idx]  = (i == 0) || (i == 8) || (i == 20) || (i == 35);
      idx++;
    end
    score_tab[idx] = 8'h8f;
    last_tab[idx]  = 1'b1;
    idx++;
    // Longest row allowed with all scores close to zero
    for (int j = 0; j < 64; j++) begin
      score_tab[idx] = (j % 3 == 0) ? 8'h00 : (j % 3 == 1) ? 8'h0f : 8'hff;
      last_tab[idx]  = (j == 63);
      idx++;
    end
    score_tab[idx]     = 8'hf4;
    last_tab[idx]      = 1'b0;
    score_tab[idx + 1] = 8'hc8;
    last_tab[idx + 1]  = 1'b1;
    run = 0;
    for (int k = 0; k < N_ITEMS; k++) begin
      exp_tab[k] = pow2_model(score_tab[k]);
      run        = run + int'(exp_tab[k]);
      if (run > 65535) begin
        run = 65535;
      end
      row_sum_tab[k] = 16'(run);
      if (last_tab[k]) begin
        run = 0;
      end
    end
  endtask

  task automatic report_timeout(string what);
    $display("Timed out waiting for %s", what);
    $display("Errors: value %0d, timing %0d, protocol %0d",
             value_errors, timing_errors, protocol_errors);
    $display("Finished with errors");
    $finish;
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || sum_q.size() != 0) && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0 || sum_q.size() != 0) begin
      report_timeout("the pipeline to drain");
    end
  endtask

  // Output ready is random only in the second pass
  initial begin
    exp_ready = 1'b1;
    lfsr      = 32'hb89a;
    forever begin
      @(posedge clk);
      #1;
      if (random_ready) begin
        lfsr      = lfsr_next(lfsr);
        exp_ready = lfsr[0];
      end else begin
        exp_ready = 1'b1;
      end
    end
  end

  // Producer
  initial begin
    int waited;
    rst_n       = 1'b0;
    score_data  = '0;
    score_last  = 1'b0;
    score_valid = 1'b0;
    build_table();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (exp_valid !== 1'b0 || sum_valid !== 1'b0 || score_ready !== 1'b1) begin
      $display("Outputs not in their reset state after reset");
      protocol_errors++;
    end
    for (int pass = 0; pass < 2; pass++) begin
      random_ready = (pass == 1);
      for (int k = 0; k < N_ITEMS; k++) begin
        @(posedge clk);
        #1;
        score_data  = score_tab[k];
        score_last  = last_tab[k];
        score_valid = 1'b1;
        waited      = 0;
        @(negedge clk);
        while (!score_ready && waited < TIMEOUT) begin
          @(negedge clk);
          waited++;
        end
        if (!score_ready) begin
          report_timeout("score_ready");
        end
      end
      @(posedge clk);
      #1;
      score_valid = 1'b0;
      score_last  = 1'b0;
      wait_for_drain();
    end
    repeat (4) @(posedge clk);
    $display("Errors: value %0d, timing %0d, protocol %0d",
             value_errors, timing_errors, protocol_errors);
    if (value_errors + timing_errors + protocol_errors != 0) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

  // Monitor samples mid-cycle where every signal is settled
  always @(negedge clk) begin
    logic [8:0]  item;
    int          taken_at;
    logic [15:0] want_sum;
    if (rst_n) begin
      if (sum_valid) begin
        if (cycle != expect_sum_at || sum_q.size() == 0) begin
          $display("sum_valid pulsed at cycle %0d with no row just finished", cycle);
          protocol_errors++;
        end else begin
          want_sum = sum_q.pop_front();
          if (sum_data !== want_sum) begin
            $display("ERROR sum_data: got 0x%h expected 0x%h", sum_data, want_sum);
            value_errors++;
          end
        end
      end else if (cycle == expect_sum_at) begin
        $display("sum_valid missing the cycle after a row ended, cycle %0d", cycle);
        protocol_errors++;
      end
      if (stall_seen) begin
        if (!exp_valid) begin
          $display("exp_valid dropped while the output was stalled");
          protocol_errors++;
        end else begin
          if (exp_data !== stall_data) begin
            $display("ERROR exp_data: changed under stall from 0x%h to 0x%h",
                     stall_data, exp_data);
            value_errors++;
          end
          if (exp_last !== stall_last) begin
            $display("ERROR exp_last: changed under stall from 0x%h to 0x%h",
                     stall_last, exp_last);
            value_errors++;
          end
        end
      end
      stall_seen = exp_valid && !exp_ready;
      stall_data = exp_data;
      stall_last = exp_last;
      if (exp_valid && exp_ready) begin
        if (exp_last) begin
          expect_sum_at = cycle + 1;
        end
        if (exp_q.size() == 0) begin
          $display("An exponential came out with no score pending");
          protocol_errors++;
        end else begin
          item     = exp_q.pop_front();
          taken_at = in_cycle_q.pop_front();
          if (exp_data !== item[8:1]) begin
            $display("ERROR exp_data: got 0x%h expected 0x%h", exp_data, item[8:1]);
            value_errors++;
          end
          if (exp_last !== item[0]) begin
            $display("ERROR exp_last: got 0x%h expected 0x%h", exp_last, item[0]);
            value_errors++;
          end
          if (!random_ready && cycle - taken_at != LATENCY) begin
            $display("Exponential arrived %0d cycles after its score instead of %0d",
                     cycle - taken_at, LATENCY);
            timing_errors++;
          end
        end
      end
      if (score_valid && score_ready) begin
        exp_q.push_back({exp_tab[in_idx], last_tab[in_idx]});
        in_cycle_q.push_back(cycle);
        if (last_tab[in_idx]) begin
          sum_q.push_back(row_sum_tab[in_idx]);
        end
        in_idx = (in_idx + 1) % N_ITEMS;
      end
    end
  end

endmodule

// File: design/softermax_row_exp.sv
`timescale 1ns/1ns

module softermax_row_exp (
  input  logic                                  clk,
  input  logic                                  rst_n,

  // Scores with the row max already removed
  input  logic [fixed_point_pkg::IN_WIDTH-1:0]  score_data,
  input  logic                                  score_last,
  input  logic                                  score_valid,
  output logic                                  score_ready,

  output logic [fixed_point_pkg::OUT_WIDTH-1:0] exp_data,
  output logic                                  exp_last,
  output logic                                  exp_valid,
  input  logic                                  exp_ready,

  // One-cycle strobe per row
  output logic [fixed_point_pkg::SUM_WIDTH-1:0] sum_data,
  output logic                                  sum_valid
);

  softermax_lpw_pow2 u_pow2 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  (score_data),
    .in_last  (score_last),
    .in_valid (score_valid),
    .in_ready (score_ready),
    .out_data (exp_data),
    .out_last (exp_last),
    .out_valid(exp_valid),
    .out_ready(exp_ready)
  );

  // Taps the output stream after the handshake
  row_sum_accumulator u_row_sum (
    .clk      (clk),
    .rst_n    (rst_n),
    .exp_data (exp_data),
    .exp_last (exp_last),
    .exp_valid(exp_valid),
    .exp_ready(exp_ready),
    .sum_data (sum_data),
    .sum_valid(sum_valid)
  );

endmodule

// File: design/row_sum_accumulator.sv
`timescale 1ns/1ns

module row_sum_accumulator (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [fixed_point_pkg::OUT_WIDTH-1:0] exp_data,
  input  logic                                  exp_last,
  input  logic                                  exp_valid,
  input  logic                                  exp_ready,
  output logic [fixed_point_pkg::SUM_WIDTH-1:0] sum_data,
  output logic                                  sum_valid
);

  softermax_pkg::acc_state_e              state;
  logic [fixed_point_pkg::SUM_WIDTH-1:0] running;
  logic [fixed_point_pkg::SUM_WIDTH-1:0] base;
  logic [fixed_point_pkg::SUM_WIDTH:0]   sum_wide;
  logic [fixed_point_pkg::SUM_WIDTH-1:0] sum_sat;
  softermax_pkg::row_cnt_t               row_cnt;
  softermax_pkg::row_cnt_t               cnt_next;
  logic                                  exp_fire;

  // Observes the stream without driving ready
  assign exp_fire = exp_valid && exp_ready;

  always_comb begin
    // Idle state starts the row from zero
    base     = (state == softermax_pkg::ACC_ROW) ? running : '0;
    sum_wide = {1'b0, base} + (fixed_point_pkg::SUM_WIDTH + 1)'(exp_data);
    sum_sat  = sum_wide[fixed_point_pkg::SUM_WIDTH] ? fixed_point_pkg::SUM_MAX
             : sum_wide[fixed_point_pkg::SUM_WIDTH-1:0];
    cnt_next = ((state == softermax_pkg::ACC_ROW) ? row_cnt : '0)
             + softermax_pkg::ROW_CNT_WIDTH'(1);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= softermax_pkg::ACC_IDLE;
      running   <= '0;
      row_cnt   <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= exp_fire && exp_last;
      if (exp_fire) begin
        if (exp_last) begin
          // Back to idle drops the partial sum
          state <= softermax_pkg::ACC_IDLE;
        end else begin
          state   <= softermax_pkg::ACC_ROW;
          running <= sum_sat;
          row_cnt <= cnt_next;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (exp_fire && exp_last) begin
      sum_data <= sum_sat;
    end
  end

  // Back-to-back pulses mean a one-element row whose sum is that element alone
  a_sum_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_valid && $past(sum_valid)
      |-> sum_data == fixed_point_pkg::SUM_WIDTH'($past(exp_data))
  );

  a_row_len : assert property (
    @(posedge clk) disable iff (!rst_n)
    exp_fire |-> cnt_next <= softermax_pkg::ROW_CNT_WIDTH'(softermax_pkg::MAX_ROW_LEN)
  );

endmodule

// File: design/softermax_lpw_pow2.sv
`timescale 1ns/1ns

module softermax_lpw_pow2 (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [fixed_point_pkg::IN_WIDTH-1:0]  in_data,
  input  logic                                  in_last,
  input  logic                                  in_valid,
  output logic                                  in_ready,
  output logic [fixed_point_pkg::OUT_WIDTH-1:0] out_data,
  output logic                                  out_last,
  output logic                                  out_valid,
  input  logic                                  out_ready
);

  logic [fixed_point_pkg::IN_INT_WIDTH-1:0]  in_int;
  logic [fixed_point_pkg::IN_FRAC_WIDTH-1:0] in_frac;
  logic [1:0]                                in_seg;

  // Multiply stage
  logic [fixed_point_pkg::MULT_WIDTH-1:0]   mult_in;
  logic [fixed_point_pkg::MULT_WIDTH-1:0]   mult_q;
  logic [1:0]                               mult_seg;
  logic [fixed_point_pkg::IN_INT_WIDTH-1:0] mult_int;
  logic                                     mult_last;
  logic                                     mult_valid;
  logic                                     mult_ready;

  // Intercept stage
  logic [fixed_point_pkg::LPW_WIDTH-1:0]    lpw_in;
  logic [fixed_point_pkg::LPW_WIDTH-1:0]    lpw_q;
  logic [fixed_point_pkg::IN_INT_WIDTH-1:0] lpw_int;
  logic                                     lpw_last;
  logic                                     lpw_valid;
  logic                                     lpw_ready;

  // Shift stage
  logic [fixed_point_pkg::IN_INT_WIDTH-1:0] shift_amt;
  logic [fixed_point_pkg::LPW_WIDTH-1:0]    shifted;
  logic [fixed_point_pkg::LPW_WIDTH-1:0]    shift_q;
  logic                                     shift_last;
  logic                                     shift_valid;
  logic                                     shift_ready;

  logic [fixed_point_pkg::OUT_WIDTH:0]      cast_out;
  logic [fixed_point_pkg::OUT_WIDTH-1:0]    result;

  assign in_int  = in_data[fixed_point_pkg::IN_WIDTH-1:fixed_point_pkg::IN_FRAC_WIDTH];
  assign in_frac = in_data[fixed_point_pkg::IN_FRAC_WIDTH-1:0];
  // Top two fraction bits pick the quarter segment
  assign in_seg  = in_frac[fixed_point_pkg::IN_FRAC_WIDTH-1:fixed_point_pkg::IN_FRAC_WIDTH-2];

  assign mult_in = fixed_point_pkg::MULT_WIDTH'(in_frac)
                 * fixed_point_pkg::MULT_WIDTH'(fixed_point_pkg::SLOPE_TABLE[in_seg]);

  skid_buffer #(
    .DATA_WIDTH(fixed_point_pkg::MULT_WIDTH + 2 + fixed_point_pkg::IN_INT_WIDTH + 1)
  ) u_mult_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  ({mult_in, in_seg, in_int, in_last}),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data ({mult_q, mult_seg, mult_int, mult_last}),
    .out_valid(mult_valid),
    .out_ready(mult_ready)
  );

  assign lpw_in = fixed_point_pkg::LPW_WIDTH'(mult_q)
                + fixed_point_pkg::LPW_WIDTH'(fixed_point_pkg::INTERCEPT_TABLE[mult_seg]);

  skid_buffer #(
    .DATA_WIDTH(fixed_point_pkg::LPW_WIDTH + fixed_point_pkg::IN_INT_WIDTH + 1)
  ) u_intercept_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  ({lpw_in, mult_int, mult_last}),
    .in_valid (mult_valid),
    .in_ready (mult_ready),
    .out_data ({lpw_q, lpw_int, lpw_last}),
    .out_valid(lpw_valid),
    .out_ready(lpw_ready)
  );

  // Negating an integer part of 0 down to -8 gives an unsigned shift
  assign shift_amt = -lpw_int;
  assign shifted   = lpw_q >> shift_amt;

  skid_buffer #(
    .DATA_WIDTH(fixed_point_pkg::LPW_WIDTH + 1)
  ) u_shift_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  ({shifted, lpw_last}),
    .in_valid (lpw_valid),
    .in_ready (lpw_ready),
    .out_data ({shift_q, shift_last}),
    .out_valid(shift_valid),
    .out_ready(shift_ready)
  );

  fixed_signed_cast u_cast (
    .in_data ({1'b0, shift_q}),
    .out_data(cast_out)
  );

  // Shifted value is never negative and leaves the cast sign bit clear
  assign result = cast_out[fixed_point_pkg::OUT_WIDTH-1:0];

  skid_buffer #(
    .DATA_WIDTH(fixed_point_pkg::OUT_WIDTH + 1)
  ) u_output_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_data  ({result, shift_last}),
    .in_valid (shift_valid),
    .in_ready (shift_ready),
    .out_data ({out_data, out_last}),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  // There is no left shift path for positive integer parts
  a_score_not_positive : assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid && in_ready |-> $signed(in_int) <= 0
  );

endmodule

// File: design/fixed_signed_cast.sv
`timescale 1ns/1ns

module fixed_signed_cast (
  input  logic [fixed_point_pkg::LPW_WIDTH:0] in_data,
  output logic [fixed_point_pkg::OUT_WIDTH:0] out_data
);

  // Input with the low fraction bits dropped, still signed
  logic [fixed_point_pkg::LPW_WIDTH - fixed_point_pkg::MULT_FRAC_WIDTH
         + fixed_point_pkg::OUT_FRAC_WIDTH:0] floored;
  logic fits;

  // Plain truncation of two's complement is a floor
  assign floored = in_data[fixed_point_pkg::LPW_WIDTH:
                           fixed_point_pkg::MULT_FRAC_WIDTH - fixed_point_pkg::OUT_FRAC_WIDTH];

  // Bits from the output sign upward must all agree
  assign fits = (&floored[$high(floored):fixed_point_pkg::OUT_WIDTH])
             || !(|floored[$high(floored):fixed_point_pkg::OUT_WIDTH]);

  always_comb begin
    if (fits) begin
      out_data = floored[fixed_point_pkg::OUT_WIDTH:0];
    end else if (floored[$high(floored)]) begin
      out_data = {1'b1, {fixed_point_pkg::OUT_WIDTH{1'b0}}};
    end else begin
      out_data = {1'b0, {fixed_point_pkg::OUT_WIDTH{1'b1}}};
    end
  end

endmodule

// File: design/skid_buffer.sv
`timescale 1ns/1ns

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  in_fire;
  logic                  out_free;

  // Ready comes straight from the skid flop, no path from out_ready
  assign in_ready = !skid_valid;
  assign in_fire  = in_valid && in_ready;
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // Skid item goes out first to keep order
      out_valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        out_data <= skid_data;
      end else if (in_fire) begin
        out_data <= in_data;
      end
    end
    // Only holds data once it is marked valid, so loading while empty is harmless
    if (in_ready) begin
      skid_data <= in_data;
    end
  end

  a_out_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

// File: design/softermax_pkg.sv
package softermax_pkg;

  // Longest row the accumulator will count
  localparam int MAX_ROW_LEN = 64;
  localparam int ROW_CNT_WIDTH = $clog2(MAX_ROW_LEN + 1);

  typedef logic [ROW_CNT_WIDTH-1:0] row_cnt_t;

  // ACC_ROW means a partial sum is being built
  typedef enum logic {
    ACC_IDLE = 1'b0,
    ACC_ROW  = 1'b1
  } acc_state_e;

endpackage

// File: design/fixed_point_pkg.sv
package fixed_point_pkg;

  // Scores are signed Q4.4 with the row maximum already subtracted
  localparam int IN_WIDTH = 8;
  localparam int IN_FRAC_WIDTH = 4;
  localparam int IN_INT_WIDTH = IN_WIDTH - IN_FRAC_WIDTH;

  // Exponentials are unsigned Q4.4
  localparam int OUT_WIDTH = 8;
  localparam int OUT_FRAC_WIDTH = 4;

  // Chord slopes lie in [0.75, 1.3) so two integer bits are enough
  localparam int SLOPE_FRAC_WIDTH = OUT_WIDTH;
  localparam int SLOPE_WIDTH = SLOPE_FRAC_WIDTH + 2;

  localparam int MULT_WIDTH = IN_WIDTH + SLOPE_WIDTH;
  localparam int MULT_FRAC_WIDTH = IN_FRAC_WIDTH + SLOPE_FRAC_WIDTH;

  // Intercept shares the product's fraction so the adder needs no alignment
  localparam int INTERCEPT_WIDTH = MULT_FRAC_WIDTH + 2;
  localparam int LPW_WIDTH = MULT_WIDTH + 1;

  // Row sum is unsigned with the exponential's fraction
  localparam int SUM_WIDTH = 16;
  localparam logic [SUM_WIDTH-1:0] SUM_MAX = '1;

  // Chord slope of 2^x over segment k, which spans k/4 to (k+1)/4
  function automatic real chord_slope(int k);
    real x_lo;
    real x_hi;
    x_lo = k / 4.0;
    x_hi = (k + 1) / 4.0;
    return (2.0 ** x_hi - 2.0 ** x_lo) / (x_hi - x_lo);
  endfunction

  function automatic logic [SLOPE_WIDTH-1:0] seg_slope(int k);
    return SLOPE_WIDTH'($rtoi(chord_slope(k) * 2.0 ** SLOPE_FRAC_WIDTH));
  endfunction

  // Intercept uses the unfloored slope
  function automatic logic [INTERCEPT_WIDTH-1:0] seg_intercept(int k);
    real x_lo;
    x_lo = k / 4.0;
    return INTERCEPT_WIDTH'($rtoi((2.0 ** x_lo - chord_slope(k) * x_lo)
                                  * 2.0 ** MULT_FRAC_WIDTH));
  endfunction

  localparam logic [3:0][SLOPE_WIDTH-1:0] SLOPE_TABLE = {
    seg_slope(3), seg_slope(2), seg_slope(1), seg_slope(0)
  };

  localparam logic [3:0][INTERCEPT_WIDTH-1:0] INTERCEPT_TABLE = {
    seg_intercept(3), seg_intercept(2), seg_intercept(1), seg_intercept(0)
  };

endpackage
